//--- verilog/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

   localparam int va_bits = 64;
   localparam int pa_bits = 56;
   localparam int pte_bits = 64;
   localparam int vpn_bits = 9;
   localparam int page_offset_bits = 12;

   localparam int tlb_index_bits = 6;
   localparam int tlb_entries = 64;

   // va bits above the 39 that get translated
   localparam int va_upper_bits = va_bits - 3 * vpn_bits - page_offset_bits;
   localparam int tlb_tag_bits = va_bits - tlb_index_bits - page_offset_bits;

   localparam int pte_valid_bit = 0;
   localparam int pte_read_bit = 1;
   localparam int pte_write_bit = 2;
   localparam int pte_exec_bit = 3;
   localparam int pte_user_bit = 4;
   localparam int pte_accessed_bit = 6;
   localparam int pte_dirty_bit = 7;

   localparam int ppn_lsb = 10;
   localparam int ppn_msb = 53;
   localparam int ppn_bits = ppn_msb - ppn_lsb + 1;

   // page size, also the level the leaf was found at
   localparam logic [1:0] level_giga = 2'd0;
   localparam logic [1:0] level_mega = 2'd1;
   localparam logic [1:0] level_kilo = 2'd2;

   typedef union packed {
      struct packed {
         logic [va_upper_bits-1:0]    upper;
         logic [vpn_bits-1:0]         vpn2;
         logic [vpn_bits-1:0]         vpn1;
         logic [vpn_bits-1:0]         vpn0;
         logic [page_offset_bits-1:0] offset;
      } walk_view;
      struct packed {
         logic [tlb_tag_bits-1:0]     tag;
         logic [tlb_index_bits-1:0]   index;
         logic [page_offset_bits-1:0] offset;
      } cache_view;
   } va_t;

endpackage

`default_nettype wire

//--- verilog/mmu_walk_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mmu_walk_if;
   import mmu_pkg::*;

   logic                start;     // one cycle
   va_t                 va;        // held through the walk
   logic                done;
   logic                fault;
   logic [pte_bits-1:0] leaf_pte;
   logic [1:0]          level;
   logic                busy;      // stays up while marking

   modport sequencer
   (
      output start,
      output va,
      input  done,
      input  fault,
      input  leaf_pte,
      input  level,
      input  busy
   );

   modport walker
   (
      input  start,
      input  va,
      output done,
      output fault,
      output leaf_pte,
      output level,
      output busy
   );

endinterface

`default_nettype wire

//--- verilog/mmu_cache_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mmu_cache_if;
   import mmu_pkg::*;

   va_t                 lookup_va;
   logic                hit;       // cycle after lookup_va
   logic [pte_bits-1:0] hit_pte;
   logic                fill;
   va_t                 fill_va;
   logic [pte_bits-1:0] fill_pte;

   modport sequencer
   (
      output lookup_va,
      input  hit,
      input  hit_pte,
      output fill,
      output fill_va,
      output fill_pte
   );

   modport cache
   (
      input  lookup_va,
      output hit,
      output hit_pte,
      input  fill,
      input  fill_va,
      input  fill_pte
   );

endinterface

`default_nettype wire

//--- verilog/translation_cache.sv
`timescale 1ns/10ps
`default_nettype none

module translation_cache
(
   input logic        clk,
   input logic        reset,
   input logic        clear_tlb,
   mmu_cache_if.cache cache
);
   import mmu_pkg::*;

   logic                      r_valid_mem [tlb_entries];
   logic [tlb_tag_bits-1:0]   r_tag_mem [tlb_entries];
   logic [pte_bits-1:0]       r_pte_mem [tlb_entries];

   logic                      r_sweep;
   logic [tlb_index_bits-1:0] r_sweep_idx;
   logic                      fill_en;

   logic                      r_rd_valid;
   logic [tlb_tag_bits-1:0]   r_rd_tag;
   logic [tlb_tag_bits-1:0]   r_lookup_tag;
   logic [pte_bits-1:0]       r_rd_pte;

   assign fill_en = cache.fill & ~r_sweep;   // no fills while sweeping

   // sweep walks every entry once, clear restarts it
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_sweep <= 1'b1;
         r_sweep_idx <= '0;
      end
      else if (clear_tlb)
      begin
         r_sweep <= 1'b1;
         r_sweep_idx <= '0;
      end
      else if (r_sweep)
      begin
         r_sweep_idx <= r_sweep_idx + 1'b1;
         if (&r_sweep_idx)
            r_sweep <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (r_sweep)
         r_valid_mem[r_sweep_idx] <= 1'b0;
      else if (fill_en)
         r_valid_mem[cache.fill_va.cache_view.index] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (fill_en)
      begin
         r_tag_mem[cache.fill_va.cache_view.index] <= cache.fill_va.cache_view.tag;
         r_pte_mem[cache.fill_va.cache_view.index] <= cache.fill_pte;
      end
   end

   // registered read, compare happens a cycle later
   always_ff @(posedge clk)
   begin
      r_rd_tag <= r_tag_mem[cache.lookup_va.cache_view.index];
      r_rd_pte <= r_pte_mem[cache.lookup_va.cache_view.index];
      r_lookup_tag <= cache.lookup_va.cache_view.tag;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         r_rd_valid <= 1'b0;
      else
         r_rd_valid <= r_valid_mem[cache.lookup_va.cache_view.index] & ~r_sweep & ~clear_tlb;
   end

   assign cache.hit = r_rd_valid & (r_rd_tag == r_lookup_tag);
   assign cache.hit_pte = r_rd_pte;

endmodule

`default_nettype wire

//--- verilog/page_table_walker.sv
`timescale 1ns/10ps
`default_nettype none

module page_table_walker
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic [mmu_pkg::va_bits-1:0]  page_table_root,
   mmu_walk_if.walker                   walk,
   output logic                         mem_req_valid,
   output logic [mmu_pkg::pa_bits-1:0]  mem_req_addr,
   input  logic                         mem_rsp_valid,
   input  logic [mmu_pkg::pte_bits-1:0] mem_rsp_data,
   output logic                         mem_mark_valid,
   output logic [mmu_pkg::pa_bits-1:0]  mem_mark_addr,
   input  logic                         mem_mark_rsp_valid
);
   import mmu_pkg::*;

   logic                r_req;
   logic                r_wait;   // read outstanding
   logic                r_done;
   logic                r_mark;
   logic                r_fault;
   logic [pa_bits-1:0]  r_addr;
   logic [pte_bits-1:0] r_pte;
   logic [1:0]          r_lvl;

   logic                leaf;
   logic                bad;
   logic [1:0]          next_lvl;
   logic [vpn_bits-1:0] next_vpn;
   logic [pa_bits-1:0]  root_addr;

   assign leaf = mem_rsp_data[pte_read_bit] | mem_rsp_data[pte_write_bit]
               | mem_rsp_data[pte_exec_bit];

   // invalid entry, or a pointer where only a leaf may be
   assign bad = ~mem_rsp_data[pte_valid_bit] | (~leaf & (r_lvl == level_kilo));

   assign next_lvl = (r_lvl == level_giga) ? level_mega : level_kilo;
   assign next_vpn = (r_lvl == level_giga) ? walk.va.walk_view.vpn1 : walk.va.walk_view.vpn0;

   assign root_addr = page_table_root[pa_bits-1:0]
                    + {{(pa_bits - vpn_bits - 3){1'b0}}, walk.va.walk_view.vpn2, 3'b000};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_req <= 1'b0;
         r_wait <= 1'b0;
         r_done <= 1'b0;
         r_mark <= 1'b0;
      end
      else
      begin
         r_req <= 1'b0;
         r_done <= 1'b0;
         if (walk.start)
         begin
            r_req <= 1'b1;
            r_wait <= 1'b1;
         end
         else if (r_wait & mem_rsp_valid)
         begin
            if (bad | leaf)
            begin
               r_wait <= 1'b0;
               r_done <= 1'b1;
            end
            else
               r_req <= 1'b1;   // descend
         end

         if (r_done & ~r_fault & ~r_pte[pte_accessed_bit])
            r_mark <= 1'b1;
         else if (mem_mark_rsp_valid)
            r_mark <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (walk.start)
      begin
         r_addr <= root_addr;
         r_lvl <= level_giga;
      end
      else if (r_wait & mem_rsp_valid)
      begin
         r_pte <= mem_rsp_data;
         r_fault <= bad;
         if (~bad & ~leaf)
         begin
            // next table is page aligned so the index just concatenates
            r_addr <= {mem_rsp_data[ppn_msb:ppn_lsb], next_vpn, 3'b000};
            r_lvl <= next_lvl;
         end
      end
   end

   assign mem_req_valid = r_req;
   assign mem_req_addr = r_addr;

   // r_addr still points at the leaf pte after the last read
   assign mem_mark_valid = r_mark;
   assign mem_mark_addr = r_addr;

   assign walk.done = r_done;
   assign walk.fault = r_fault;
   assign walk.leaf_pte = r_pte;
   assign walk.level = r_lvl;
   assign walk.busy = r_wait | r_done | r_mark;

endmodule

`default_nettype wire

//--- verilog/translation_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module translation_sequencer
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        l1i_req,
   input  logic                        l1d_req,
   input  logic [mmu_pkg::va_bits-1:0] l1i_va,
   input  logic [mmu_pkg::va_bits-1:0] l1d_va,
   output logic                        l1i_gnt,
   output logic                        l1d_gnt,
   output logic                        l1i_rsp_valid,
   output logic                        l1d_rsp_valid,
   output logic [mmu_pkg::pa_bits-1:0] rsp_paddr,
   output logic                        rsp_fault,
   output logic                        rsp_dirty,
   output logic                        rsp_readable,
   output logic                        rsp_writable,
   output logic                        rsp_executable,
   output logic                        rsp_user,
   output logic [1:0]                  rsp_pgsize,
   mmu_walk_if.sequencer               walk,
   mmu_cache_if.sequencer              cache
);
   import mmu_pkg::*;

   logic                r_pend_i;
   logic                r_pend_d;
   logic                r_check;    // grant cycle, cache result valid
   logic                r_walking;
   logic                r_start;
   logic                r_side_i;
   va_t                 r_va;

   logic                req_i;
   logic                req_d;
   logic                idle;
   logic                accept_i;
   logic                accept_d;
   logic                canonical;
   logic                miss;
   va_t                 sel_va;

   logic                respond;
   logic                sel_fault;
   logic [pte_bits-1:0] sel_pte;
   logic [1:0]          sel_level;
   logic [ppn_bits-1:0] ppn;
   logic [pa_bits-1:0]  paddr;

   assign req_i = r_pend_i | l1i_req;
   assign req_d = r_pend_d | l1d_req;
   assign idle = ~r_check & ~r_walking;
   assign accept_i = idle & ~walk.busy & req_i;
   assign accept_d = idle & ~walk.busy & ~req_i & req_d;   // iside first

   assign sel_va = req_i ? l1i_va : l1d_va;
   assign cache.lookup_va = sel_va;

   // bits 63..38 all equal
   assign canonical = (&{r_va.walk_view.upper, r_va.walk_view.vpn2[vpn_bits-1]})
                    | ~(|{r_va.walk_view.upper, r_va.walk_view.vpn2[vpn_bits-1]});
   assign miss = r_check & canonical & ~cache.hit;

   always_comb
   begin
      respond = 1'b0;
      sel_fault = 1'b0;
      sel_pte = cache.hit_pte;
      sel_level = level_kilo;   // only 4k pages get cached
      if (r_check)
      begin
         if (!canonical)
         begin
            respond = 1'b1;
            sel_fault = 1'b1;
         end
         else if (cache.hit)
            respond = 1'b1;
      end
      else if (r_walking & walk.done)
      begin
         respond = 1'b1;
         sel_pte = walk.leaf_pte;
         sel_level = walk.level;
         sel_fault = walk.fault;
      end
   end

   assign ppn = sel_pte[ppn_msb:ppn_lsb];

   always_comb
   begin
      case (sel_level)
         level_giga:
            paddr = {ppn[ppn_bits-1:2*vpn_bits], r_va.walk_view.vpn1,
                     r_va.walk_view.vpn0, r_va.walk_view.offset};
         level_mega:
            paddr = {ppn[ppn_bits-1:vpn_bits], r_va.walk_view.vpn0, r_va.walk_view.offset};
         default:
            paddr = {ppn, r_va.walk_view.offset};
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_pend_i <= 1'b0;
         r_pend_d <= 1'b0;
         r_check <= 1'b0;
         r_walking <= 1'b0;
         r_start <= 1'b0;
         l1i_gnt <= 1'b0;
         l1d_gnt <= 1'b0;
         l1i_rsp_valid <= 1'b0;
         l1d_rsp_valid <= 1'b0;
      end
      else
      begin
         r_pend_i <= req_i & ~accept_i;
         r_pend_d <= req_d & ~accept_d;
         l1i_gnt <= accept_i;
         l1d_gnt <= accept_d;
         r_check <= accept_i | accept_d;
         r_start <= miss;
         r_walking <= (r_walking & ~walk.done) | miss;
         l1i_rsp_valid <= respond & r_side_i;
         l1d_rsp_valid <= respond & ~r_side_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept_i | accept_d)
      begin
         r_va <= sel_va;
         r_side_i <= accept_i;
      end
   end

   // fields hold until the next response
   always_ff @(posedge clk)
   begin
      if (respond)
      begin
         rsp_paddr <= paddr;
         rsp_fault <= sel_fault;
         rsp_dirty <= sel_pte[pte_dirty_bit] & ~sel_fault;
         rsp_readable <= sel_pte[pte_read_bit] & ~sel_fault;
         rsp_writable <= sel_pte[pte_write_bit] & ~sel_fault;
         rsp_executable <= sel_pte[pte_exec_bit] & ~sel_fault;
         rsp_user <= sel_pte[pte_user_bit] & ~sel_fault;
         rsp_pgsize <= sel_level;
      end
   end

   assign walk.start = r_start;
   assign walk.va = r_va;

   assign cache.fill = r_walking & walk.done & ~walk.fault & (walk.level == level_kilo);
   assign cache.fill_va = r_va;
   assign cache.fill_pte = walk.leaf_pte;

endmodule

`default_nettype wire

//--- verilog/mmu_top.sv
`timescale 1ns/10ps
`default_nettype none

module mmu_top
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         clear_tlb,
   input  logic [mmu_pkg::va_bits-1:0]  page_table_root,
   input  logic                         l1i_req,
   input  logic [mmu_pkg::va_bits-1:0]  l1i_va,
   input  logic                         l1d_req,
   input  logic [mmu_pkg::va_bits-1:0]  l1d_va,
   output logic                         l1i_gnt,
   output logic                         l1d_gnt,
   output logic                         l1i_rsp_valid,
   output logic                         l1d_rsp_valid,
   output logic [mmu_pkg::pa_bits-1:0]  rsp_paddr,
   output logic                         rsp_fault,
   output logic                         rsp_dirty,
   output logic                         rsp_readable,
   output logic                         rsp_writable,
   output logic                         rsp_executable,
   output logic                         rsp_user,
   output logic [1:0]                   rsp_pgsize,
   output logic                         mem_req_valid,
   output logic [mmu_pkg::pa_bits-1:0]  mem_req_addr,
   input  logic                         mem_rsp_valid,
   input  logic [mmu_pkg::pte_bits-1:0] mem_rsp_data,
   output logic                         mem_mark_valid,
   output logic [mmu_pkg::pa_bits-1:0]  mem_mark_addr,
   input  logic                         mem_mark_rsp_valid
);

   mmu_walk_if  walk_bus ();
   mmu_cache_if cache_bus ();

   translation_cache u_cache
   (
      .clk       (clk),
      .reset     (reset),
      .clear_tlb (clear_tlb),
      .cache     (cache_bus.cache)
   );

   page_table_walker u_walker
   (
      .clk                (clk),
      .reset              (reset),
      .page_table_root    (page_table_root),
      .walk               (walk_bus.walker),
      .mem_req_valid      (mem_req_valid),
      .mem_req_addr       (mem_req_addr),
      .mem_rsp_valid      (mem_rsp_valid),
      .mem_rsp_data       (mem_rsp_data),
      .mem_mark_valid     (mem_mark_valid),
      .mem_mark_addr      (mem_mark_addr),
      .mem_mark_rsp_valid (mem_mark_rsp_valid)
   );

   translation_sequencer u_sequencer
   (
      .clk            (clk),
      .reset          (reset),
      .l1i_req        (l1i_req),
      .l1d_req        (l1d_req),
      .l1i_va         (l1i_va),
      .l1d_va         (l1d_va),
      .l1i_gnt        (l1i_gnt),
      .l1d_gnt        (l1d_gnt),
      .l1i_rsp_valid  (l1i_rsp_valid),
      .l1d_rsp_valid  (l1d_rsp_valid),
      .rsp_paddr      (rsp_paddr),
      .rsp_fault      (rsp_fault),
      .rsp_dirty      (rsp_dirty),
      .rsp_readable   (rsp_readable),
      .rsp_writable   (rsp_writable),
      .rsp_executable (rsp_executable),
      .rsp_user       (rsp_user),
      .rsp_pgsize     (rsp_pgsize),
      .walk           (walk_bus.sequencer),
      .cache          (cache_bus.sequencer)
   );

endmodule

`default_nettype wire

//--- testbench/page_table_model.sv
`timescale 1ns/10ps
`default_nettype none

module page_table_model
#(
   parameter logic [55:0] table_base = 56'h10000,
   parameter int          seed = 26
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        req_valid,
   input  logic [55:0] req_addr,
   output logic        rsp_valid,
   output logic [63:0] rsp_data,
   input  logic        mark_valid,
   input  logic [55:0] mark_addr,
   output logic        mark_rsp_valid
);

   // three table pages, L2 at the base, then L1, then L0
   localparam int table_entries = 1536;

   logic [63:0] entry [table_entries];
   logic [31:0] lcg_state = seed;

   logic        rd_busy;
   logic [1:0]  rd_cnt;
   logic [55:0] rd_addr;
   logic        mk_busy;
   logic [1:0]  mk_cnt;

   function automatic logic [1:0] next_delay();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[17:16];
   endfunction

   function automatic logic [63:0] make_pte(input logic [43:0] ppn, input logic [9:0] flags);
      return {10'b0, ppn, flags};
   endfunction

   function automatic int entry_index(input logic [55:0] addr);
      return int'((addr - table_base) >> 3);
   endfunction

   function automatic logic [63:0] read_entry(input logic [55:0] addr);
      if (addr < table_base || entry_index(addr) >= table_entries)
         return 64'b0;
      return entry[entry_index(addr)];
   endfunction

   initial
   begin
      for (int i = 0; i < table_entries; i++)
         entry[i] = 64'b0;
      entry[0] = make_pte(44'h11, 10'h001);         // pointer to L1
      entry[1] = make_pte(44'h40000, 10'h0cf);      // 1 GiB leaf
      entry[2] = make_pte(44'h0, 10'h002);          // valid clear
      entry[512] = make_pte(44'h12, 10'h001);       // pointer to L0
      entry[513] = make_pte(44'h200, 10'h053);      // 2 MiB leaf
      entry[1024] = make_pte(44'h1000, 10'h007);    // accessed clear
      entry[1025] = make_pte(44'h1011, 10'h04b);
      entry[1026] = make_pte(44'h1022, 10'h097);    // accessed clear, dirty
      entry[1027] = make_pte(44'h1033, 10'h0c3);
   end

   always @(posedge clk)
   begin
      if (reset)
      begin
         rd_busy <= 1'b0;
         mk_busy <= 1'b0;
         rsp_valid <= 1'b0;
         rsp_data <= 64'b0;
         mark_rsp_valid <= 1'b0;
      end
      else
      begin
         rsp_valid <= 1'b0;
         mark_rsp_valid <= 1'b0;
         if (req_valid)
         begin
            rd_busy <= 1'b1;
            rd_addr <= req_addr;
            rd_cnt <= next_delay();
         end
         else if (rd_busy)
         begin
            if (rd_cnt == 2'd0)
            begin
               rsp_valid <= 1'b1;
               rsp_data <= read_entry(rd_addr);
               rd_busy <= 1'b0;
            end
            else
               rd_cnt <= rd_cnt - 2'd1;
         end

         if (mk_busy)
         begin
            if (mk_cnt == 2'd0)
            begin
               mark_rsp_valid <= 1'b1;
               mk_busy <= 1'b0;
               if (mark_addr >= table_base && entry_index(mark_addr) < table_entries)
                  entry[entry_index(mark_addr)][6] <= 1'b1;   // accessed
            end
            else
               mk_cnt <= mk_cnt - 2'd1;
         end
         else if (mark_valid && !mark_rsp_valid)
         begin
            mk_busy <= 1'b1;
            mk_cnt <= next_delay();
         end
      end
   end

endmodule

`default_nettype wire

//--- testbench/mmu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mmu_tb;

   localparam logic [55:0] table_base = 56'h10000;
   // about a dozen walks of under 40 cycles each plus two sweeps, with margin
   localparam int timeout_cycles = 4000;

   logic        clk;
   logic        reset;
   logic        clear_tlb;
   logic [63:0] page_table_root;
   logic        l1i_req;
   logic [63:0] l1i_va;
   logic        l1d_req;
   logic [63:0] l1d_va;
   logic        l1i_gnt;
   logic        l1d_gnt;
   logic        l1i_rsp_valid;
   logic        l1d_rsp_valid;
   logic [55:0] rsp_paddr;
   logic        rsp_fault;
   logic        rsp_dirty;
   logic        rsp_readable;
   logic        rsp_writable;
   logic        rsp_executable;
   logic        rsp_user;
   logic [1:0]  rsp_pgsize;
   logic        mem_req_valid;
   logic [55:0] mem_req_addr;
   logic        mem_rsp_valid;
   logic [63:0] mem_rsp_data;
   logic        mem_mark_valid;
   logic [55:0] mem_mark_addr;
   logic        mem_mark_rsp_valid;

   // expectations per side, 0 is l1i and 1 is l1d
   logic [62:0] exp_word [2];
   logic [1:0]  exp_fault;
   logic [1:0]  exp_fast;     // answer at grant+1
   logic [1:0]  exp_read;
   logic [1:0]  exp_mark;
   logic [55:0] exp_mark_addr [2];

   logic        in_flight;
   logic        cur_side;
   logic        read_seen;
   logic        i_pending;
   logic        mark_q;
   int          marks_seen;
   int          marks_expected;
   int          cycles;
   logic [31:0] lcg_state;
   logic [62:0] rsp_word;

   assign rsp_word = {rsp_paddr, rsp_pgsize, rsp_dirty, rsp_readable, rsp_writable,
                      rsp_executable, rsp_user};

   mmu_top uut
   (
      .clk                (clk),
      .reset              (reset),
      .clear_tlb          (clear_tlb),
      .page_table_root    (page_table_root),
      .l1i_req            (l1i_req),
      .l1i_va             (l1i_va),
      .l1d_req            (l1d_req),
      .l1d_va             (l1d_va),
      .l1i_gnt            (l1i_gnt),
      .l1d_gnt            (l1d_gnt),
      .l1i_rsp_valid      (l1i_rsp_valid),
      .l1d_rsp_valid      (l1d_rsp_valid),
      .rsp_paddr          (rsp_paddr),
      .rsp_fault          (rsp_fault),
      .rsp_dirty          (rsp_dirty),
      .rsp_readable       (rsp_readable),
      .rsp_writable       (rsp_writable),
      .rsp_executable     (rsp_executable),
      .rsp_user           (rsp_user),
      .rsp_pgsize         (rsp_pgsize),
      .mem_req_valid      (mem_req_valid),
      .mem_req_addr       (mem_req_addr),
      .mem_rsp_valid      (mem_rsp_valid),
      .mem_rsp_data       (mem_rsp_data),
      .mem_mark_valid     (mem_mark_valid),
      .mem_mark_addr      (mem_mark_addr),
      .mem_mark_rsp_valid (mem_mark_rsp_valid)
   );

   page_table_model #(.table_base(table_base), .seed(26)) tables
   (
      .clk            (clk),
      .reset          (reset),
      .req_valid      (mem_req_valid),
      .req_addr       (mem_req_addr),
      .rsp_valid      (mem_rsp_valid),
      .rsp_data       (mem_rsp_data),
      .mark_valid     (mem_mark_valid),
      .mark_addr      (mem_mark_addr),
      .mark_rsp_valid (mem_mark_rsp_valid)
   );

   always #4 clk = ~clk;

   task automatic report_failure(input string msg);
      $display("FAIL %0t: %s", $time, msg);
      $display("test failed");
      $fatal(1);
   endtask

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic logic [63:0] read_pte(input logic [55:0] addr);
      int idx;
      idx = int'((addr - table_base) >> 3);
      if (addr < table_base || idx >= 1536)
         return 64'b0;
      return tables.entry[idx];
   endfunction

   // Sv39 walk over the tables, level 0 is the top
   function automatic void ref_walk(input logic [63:0] va, output logic fault,
                                    output logic [63:0] pte, output logic [1:0] level,
                                    output logic [55:0] pte_addr);
      logic [55:0] addr;
      logic [63:0] e;
      logic        stop;
      fault = 1'b0;
      stop = 1'b0;
      pte = 64'b0;
      level = 2'd0;
      pte_addr = 56'b0;
      addr = table_base + (56'(va[38:30]) << 3);
      for (int lvl = 0; lvl < 3 && !stop; lvl++)
      begin
         e = read_pte(addr);
         pte = e;
         pte_addr = addr;
         level = 2'(lvl);
         if (!e[0] || (e[3:1] == 3'b0 && lvl == 2))
         begin
            fault = 1'b1;
            stop = 1'b1;
         end
         else if (e[3:1] != 3'b0)
            stop = 1'b1;
         else
            addr = {e[53:10], 12'h0} + (56'(lvl == 0 ? va[29:21] : va[20:12]) << 3);
      end
   endfunction

   function automatic logic rsp_matches(input logic side);
      if (exp_fault[side])
         return rsp_fault && rsp_word[4:0] == 5'b0;
      return !rsp_fault && rsp_word == exp_word[side];
   endfunction

   task automatic set_expect(input logic side, input logic [63:0] va, input logic cached);
      logic        fault;
      logic [63:0] pte;
      logic [1:0]  level;
      logic [55:0] pte_addr;
      logic [55:0] paddr;
      if (va[63:38] != {26{va[38]}})
      begin
         exp_fault[side] = 1'b1;
         exp_fast[side] = 1'b1;
         exp_read[side] = 1'b0;
         exp_mark[side] = 1'b0;
      end
      else
      begin
         ref_walk(va, fault, pte, level, pte_addr);
         case (level)
            2'd0: paddr = {pte[53:28], va[29:0]};
            2'd1: paddr = {pte[53:19], va[20:0]};
            default: paddr = {pte[53:10], va[11:0]};
         endcase
         exp_word[side] = {paddr, level, pte[7], pte[1], pte[2], pte[3], pte[4]};
         exp_fault[side] = fault;
         exp_fast[side] = cached;
         exp_read[side] = !cached;
         exp_mark[side] = !cached && !fault && !pte[6];
         exp_mark_addr[side] = pte_addr;
         if (exp_mark[side])
            marks_expected++;
      end
   endtask

   task automatic wait_response(input logic side);
      do
         @(posedge clk);
      while (side ? !l1d_rsp_valid : !l1i_rsp_valid);
   endtask

   task automatic translate(input logic side, input logic [63:0] va, input logic cached);
      while (mem_mark_valid)
         @(posedge clk);
      @(posedge clk);
      set_expect(side, va, cached);
      if (side)
      begin
         l1d_va <= va;
         l1d_req <= 1'b1;
      end
      else
      begin
         l1i_va <= va;
         l1i_req <= 1'b1;
      end
      @(posedge clk);
      l1i_req <= 1'b0;
      l1d_req <= 1'b0;
      wait_response(side);
   endtask

   function automatic logic [63:0] va_4k(input int k);
      return (64'(k) << 12) | 64'(next_rand() & 32'hfff);
   endfunction

   always @(posedge clk)
   begin
      if (reset)
      begin
         in_flight <= 1'b0;
         cur_side <= 1'b0;
         read_seen <= 1'b0;
         i_pending <= 1'b0;
         mark_q <= 1'b0;
         marks_seen <= 0;
      end
      else
      begin
         if (l1i_gnt || l1d_gnt)
         begin
            in_flight <= 1'b1;
            cur_side <= l1d_gnt;
         end
         else if (l1i_rsp_valid || l1d_rsp_valid)
            in_flight <= 1'b0;
         if (l1i_gnt || l1d_gnt)
            read_seen <= 1'b0;
         else if (mem_req_valid)
            read_seen <= 1'b1;
         i_pending <= (i_pending | l1i_req) & ~l1i_rsp_valid;
         mark_q <= mem_mark_valid;
         if (mem_mark_valid && !mark_q)
            marks_seen <= marks_seen + 1;
      end
   end

   a_one_grant: assert property (@(posedge clk) disable iff (reset)
      (l1i_gnt || l1d_gnt) |-> !in_flight && !(l1i_gnt && l1d_gnt))
      else report_failure("grant while a translation is in flight");
   a_i_side: assert property (@(posedge clk) disable iff (reset)
      l1i_rsp_valid |-> in_flight && !cur_side && !l1d_rsp_valid)
      else report_failure("l1i response without its grant");
   a_d_side: assert property (@(posedge clk) disable iff (reset)
      l1d_rsp_valid |-> in_flight && cur_side)
      else report_failure("l1d response without its grant");
   a_i_first: assert property (@(posedge clk) disable iff (reset)
      l1d_gnt |-> !i_pending)
      else report_failure("l1d granted before the l1i response");
   a_i_fields: assert property (@(posedge clk) disable iff (reset)
      l1i_rsp_valid |-> rsp_matches(1'b0))
      else report_failure("l1i response fields differ from the table");
   a_d_fields: assert property (@(posedge clk) disable iff (reset)
      l1d_rsp_valid |-> rsp_matches(1'b1))
      else report_failure("l1d response fields differ from the table");
   a_fast: assert property (@(posedge clk) disable iff (reset)
      (l1i_gnt || l1d_gnt) && exp_fast[l1d_gnt] |=> (l1i_rsp_valid || l1d_rsp_valid))
      else report_failure("no response at grant+1");
   a_no_read: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |-> !(in_flight && exp_fast[cur_side]))
      else report_failure("memory read on a hit or non-canonical address");
   a_read: assert property (@(posedge clk) disable iff (reset)
      (l1i_rsp_valid || l1d_rsp_valid) && exp_read[cur_side] |-> read_seen)
      else report_failure("response without a table walk");
   a_mark: assert property (@(posedge clk) disable iff (reset)
      $rose(mem_mark_valid) |-> exp_mark[cur_side]
                                && mem_mark_addr == exp_mark_addr[cur_side])
      else report_failure("unexpected mark or wrong mark address");

   initial
   begin
      cycles = 0;
      while (cycles < timeout_cycles)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the run hung after %0d cycles", cycles);
      $display("test failed");
      $fatal(1);
   end

   initial
   begin
      logic [63:0] va_page0;
      clk = 1'b0;
      reset = 1'b1;
      clear_tlb = 1'b0;
      page_table_root = {8'b0, table_base};
      l1i_req = 1'b0;
      l1d_req = 1'b0;
      l1i_va = 64'b0;
      l1d_va = 64'b0;
      lcg_state = 32'd26;
      marks_expected = 0;
      exp_fault = 2'b0;
      exp_fast = 2'b0;
      exp_read = 2'b0;
      exp_mark = 2'b0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      repeat (70) @(posedge clk);   // initial sweep

      va_page0 = va_4k(0);
      translate(1'b0, va_page0, 1'b0);        // walk, marks
      translate(1'b1, va_4k(2), 1'b0);
      translate(1'b1, (64'd1 << 21) | 64'(next_rand() & 32'h1fffff), 1'b0);
      translate(1'b0, (64'd1 << 30) | 64'(next_rand() & 32'h3fffffff), 1'b0);
      translate(1'b0, va_4k(0), 1'b1);        // cached page, new offset
      translate(1'b1, 64'h0000_0040_0000_0000, 1'b0);
      translate(1'b0, 64'd2 << 30, 1'b0);     // invalid entry

      // same-cycle requests
      while (mem_mark_valid)
         @(posedge clk);
      @(posedge clk);
      l1i_va <= va_4k(3);
      l1d_va <= (64'd1 << 21) | 64'(next_rand() & 32'h1fffff);
      @(posedge clk);
      set_expect(1'b0, l1i_va, 1'b0);
      set_expect(1'b1, l1d_va, 1'b0);
      l1i_req <= 1'b1;
      l1d_req <= 1'b1;
      @(posedge clk);
      l1i_req <= 1'b0;
      l1d_req <= 1'b0;
      wait_response(1'b0);
      wait_response(1'b1);

      @(posedge clk);
      clear_tlb <= 1'b1;
      @(posedge clk);
      clear_tlb <= 1'b0;
      repeat (70) @(posedge clk);
      translate(1'b0, va_page0, 1'b0);        // walked again, already accessed
      translate(1'b1, va_page0, 1'b1);
      repeat (10) @(posedge clk);

      if (marks_seen != marks_expected)
         report_failure("number of marks differs from the accessed bits in the table");
      else
      begin
         $display("test passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- mmu_top.f
verilog/mmu_pkg.sv
verilog/mmu_walk_if.sv
verilog/mmu_cache_if.sv
verilog/translation_cache.sv
verilog/page_table_walker.sv
verilog/translation_sequencer.sv
verilog/mmu_top.sv
testbench/page_table_model.sv
testbench/mmu_tb.sv

//--- Bender.yml
package:
  name: mmu_top

sources:
  - verilog/mmu_pkg.sv
  - verilog/mmu_walk_if.sv
  - verilog/mmu_cache_if.sv
  - verilog/translation_cache.sv
  - verilog/page_table_walker.sv
  - verilog/translation_sequencer.sv
  - verilog/mmu_top.sv
  - target: test
    files:
      - testbench/page_table_model.sv
      - testbench/mmu_tb.sv
